// File: design/bus_defs.svh
`ifndef BUS_DEFS_SVH
`define BUS_DEFS_SVH

// Bus widths
`define WB_ADDR_W 32
`define WB_DATA_W 32
`define WB_SEL_W 4

// Words per on-chip memory window
`define RAM_WORDS 1024

// Memory windows, 4 MB each
`define RAM0_BASE 32'h8000_0000
`define RAM1_BASE 32'h8040_0000
`define RAM_MASK 32'hFFC0_0000

// Core-local timer window, 1 MB
`define CLINT_BASE 32'h0200_0000
`define CLINT_MASK 32'hFFF0_0000

// Timer register offsets inside the window
`define CLINT_MTIMECMP_LO 32'h0000_4000
`define CLINT_MTIMECMP_HI 32'h0000_4004
`define CLINT_MTIME_LO 32'h0000_BFF8
`define CLINT_MTIME_HI 32'h0000_BFFC

`endif

// File: design/wb_bus_pkg.sv
`include "bus_defs.svh"

package wb_bus_pkg;

    // Bus payload vectors
    typedef logic [`WB_ADDR_W-1:0] wb_addr_t;
    typedef logic [`WB_DATA_W-1:0] wb_data_t;
    typedef logic [`WB_SEL_W-1:0]  wb_sel_t;

    // Owner of the shared bus
    typedef enum logic [1:0] {
        MST_NONE = 2'd0,
        MST_INST = 2'd1,
        MST_DATA = 2'd2
    } master_id_e;

endpackage

// File: design/memory_map_pkg.sv
package memory_map_pkg;

    // Decoded target of the granted request
    typedef enum logic [1:0] {
        SEL_RAM0  = 2'd0,
        SEL_RAM1  = 2'd1,
        SEL_CLINT = 2'd2,
        SEL_NONE  = 2'd3
    } slave_sel_e;

    // Timer register picked by the window offset
    typedef enum logic [1:0] {
        REG_MTIMECMP_LO = 2'd0,
        REG_MTIMECMP_HI = 2'd1,
        REG_MTIME_LO    = 2'd2,
        REG_MTIME_HI    = 2'd3
    } clint_reg_e;

endpackage

// File: design/wb_if.sv
`timescale 1ns/1ps

interface wb_if import wb_bus_pkg::*; ();

    // Request side
    wb_addr_t adr;
    wb_data_t dat_w;
    logic     we;
    wb_sel_t  sel;
    logic     stb;
    logic     cyc;

    // Response side
    wb_data_t dat_r;
    logic     ack;
    logic     err;

    modport master (
        output adr, dat_w, we, sel, stb, cyc,
        input  dat_r, ack, err
    );

    modport slave (
        input  adr, dat_w, we, sel, stb, cyc,
        output dat_r, ack, err
    );

endinterface

// File: design/wb_arbiter.sv
`timescale 1ns/1ps

module wb_arbiter import wb_bus_pkg::*; (
    input logic sys_clk,
    input logic sys_rst,
    wb_if.slave  inst_m,
    wb_if.slave  data_m,
    wb_if.master bus_m
);

    master_id_e grant;
    logic       xfer_done;
    logic       use_data;

    // Transfer ends on either response
    assign xfer_done = bus_m.ack | bus_m.err;
    assign use_data  = (grant == MST_DATA);

    // Grant register, data port wins a tie
    always_ff @(posedge sys_clk or posedge sys_rst) begin
        if (sys_rst) begin
            grant <= MST_NONE;
        end else begin
            case (grant)
                MST_NONE: begin
                    if (data_m.cyc) begin
                        grant <= MST_DATA;
                    end else if (inst_m.cyc) begin
                        grant <= MST_INST;
                    end
                end
                default: begin
                    // Hold until the slave answers
                    if (xfer_done) begin
                        grant <= MST_NONE;
                    end
                end
            endcase
        end
    end

    // Forward the granted request
    always_comb begin
        bus_m.adr   = use_data ? data_m.adr : inst_m.adr;
        bus_m.dat_w = use_data ? data_m.dat_w : inst_m.dat_w;
        bus_m.we    = use_data ? data_m.we : inst_m.we;
        bus_m.sel   = use_data ? data_m.sel : inst_m.sel;
        // No strobe while the bus is idle
        bus_m.stb   = 1'b0;
        bus_m.cyc   = 1'b0;
        if (grant == MST_DATA) begin
            bus_m.stb = data_m.stb;
            bus_m.cyc = data_m.cyc;
        end else if (grant == MST_INST) begin
            bus_m.stb = inst_m.stb;
            bus_m.cyc = inst_m.cyc;
        end
    end

    // Read data is shared, handshake goes to the owner only
    assign data_m.dat_r = bus_m.dat_r;
    assign inst_m.dat_r = bus_m.dat_r;
    assign data_m.ack   = bus_m.ack & (grant == MST_DATA);
    assign data_m.err   = bus_m.err & (grant == MST_DATA);
    assign inst_m.ack   = bus_m.ack & (grant == MST_INST);
    assign inst_m.err   = bus_m.err & (grant == MST_INST);

endmodule

// File: design/wb_addr_decoder.sv
`timescale 1ns/1ps
`include "bus_defs.svh"

module wb_addr_decoder import wb_bus_pkg::*, memory_map_pkg::*; (
    input logic sys_clk,
    input logic sys_rst,
    wb_if.slave  bus_s,
    wb_if.master bus_ram0,
    wb_if.master bus_ram1,
    wb_if.master bus_clint
);

    slave_sel_e slv_sel;
    logic       req;
    logic       err_q;

    // Window hit under base and mask
    function automatic logic win_hit(wb_addr_t a, wb_addr_t base, wb_addr_t mask);
        return (a & mask) == base;
    endfunction

    always_comb begin
        if (win_hit(bus_s.adr, `RAM0_BASE, `RAM_MASK)) begin
            slv_sel = SEL_RAM0;
        end else if (win_hit(bus_s.adr, `RAM1_BASE, `RAM_MASK)) begin
            slv_sel = SEL_RAM1;
        end else if (win_hit(bus_s.adr, `CLINT_BASE, `CLINT_MASK)) begin
            slv_sel = SEL_CLINT;
        end else begin
            slv_sel = SEL_NONE;
        end
    end

    assign req = bus_s.cyc & bus_s.stb;

    // Payload broadcast to every slave
    assign bus_ram0.adr   = bus_s.adr;
    assign bus_ram0.dat_w = bus_s.dat_w;
    assign bus_ram0.we    = bus_s.we;
    assign bus_ram0.sel   = bus_s.sel;
    assign bus_ram1.adr   = bus_s.adr;
    assign bus_ram1.dat_w = bus_s.dat_w;
    assign bus_ram1.we    = bus_s.we;
    assign bus_ram1.sel   = bus_s.sel;
    assign bus_clint.adr   = bus_s.adr;
    assign bus_clint.dat_w = bus_s.dat_w;
    assign bus_clint.we    = bus_s.we;
    assign bus_clint.sel   = bus_s.sel;

    // Strobe and cycle only to the hit window
    assign bus_ram0.stb  = bus_s.stb & (slv_sel == SEL_RAM0);
    assign bus_ram0.cyc  = bus_s.cyc & (slv_sel == SEL_RAM0);
    assign bus_ram1.stb  = bus_s.stb & (slv_sel == SEL_RAM1);
    assign bus_ram1.cyc  = bus_s.cyc & (slv_sel == SEL_RAM1);
    assign bus_clint.stb = bus_s.stb & (slv_sel == SEL_CLINT);
    assign bus_clint.cyc = bus_s.cyc & (slv_sel == SEL_CLINT);

    // Own error pulse for unmapped addresses
    always_ff @(posedge sys_clk or posedge sys_rst) begin
        if (sys_rst) begin
            err_q <= 1'b0;
        end else begin
            err_q <= req & (slv_sel == SEL_NONE) & ~err_q;
        end
    end

    // Response merge, address is still held in the ack cycle
    always_comb begin
        case (slv_sel)
            SEL_RAM0:  bus_s.dat_r = bus_ram0.dat_r;
            SEL_RAM1:  bus_s.dat_r = bus_ram1.dat_r;
            SEL_CLINT: bus_s.dat_r = bus_clint.dat_r;
            default:   bus_s.dat_r = '0;
        endcase
    end

    assign bus_s.ack = bus_ram0.ack | bus_ram1.ack | bus_clint.ack;
    assign bus_s.err = err_q | bus_ram0.err | bus_ram1.err | bus_clint.err;

endmodule

// File: design/wb_sram_slave.sv
`timescale 1ns/1ps
`include "bus_defs.svh"

module wb_sram_slave import wb_bus_pkg::*; #(
    parameter int WORDS = `RAM_WORDS
) (
    input logic sys_clk,
    input logic sys_rst,
    wb_if.slave bus_s
);

    localparam int IDX_W = $clog2(WORDS);

    wb_data_t         mem [WORDS];
    wb_data_t         rd_q;
    logic [IDX_W-1:0] idx;
    logic             ack_q;
    logic             access;

    // Word index, upper address bits alias
    assign idx = bus_s.adr[IDX_W+1:2];

    // New access only, not the ack cycle
    assign access = bus_s.cyc & bus_s.stb & ~ack_q;

    always_ff @(posedge sys_clk or posedge sys_rst) begin
        if (sys_rst) begin
            ack_q <= 1'b0;
        end else begin
            ack_q <= access;
        end
    end

    // Byte-lane writes and registered read
    always_ff @(posedge sys_clk) begin
        if (access) begin
            rd_q <= mem[idx];
            if (bus_s.we) begin
                for (int b = 0; b < `WB_SEL_W; b++) begin
                    if (bus_s.sel[b]) begin
                        mem[idx][8*b +: 8] <= bus_s.dat_w[8*b +: 8];
                    end
                end
            end
        end
    end

    assign bus_s.dat_r = rd_q;
    assign bus_s.ack   = ack_q;
    // Memory never faults
    assign bus_s.err   = 1'b0;

endmodule

// File: design/clint_timer.sv
`timescale 1ns/1ps
`include "bus_defs.svh"

module clint_timer import wb_bus_pkg::*, memory_map_pkg::*; (
    input  logic sys_clk,
    input  logic sys_rst,
    wb_if.slave  bus_s,
    output logic timer_irq_o
);

    logic [63:0] mtime;
    logic [63:0] mtimecmp;
    wb_addr_t    offset;
    clint_reg_e  reg_sel;
    logic        reg_hit;
    wb_data_t    rd_word;
    wb_data_t    rd_q;
    logic        ack_q;
    logic        access;

    // Byte-lane merge of a 32-bit half
    function automatic wb_data_t merge_bytes(wb_data_t old_w, wb_data_t new_w, wb_sel_t sel);
        wb_data_t res;
        res = old_w;
        for (int b = 0; b < `WB_SEL_W; b++) begin
            if (sel[b]) begin
                res[8*b +: 8] = new_w[8*b +: 8];
            end
        end
        return res;
    endfunction

    // Offset inside the timer window
    assign offset = bus_s.adr & ~`CLINT_MASK;

    always_comb begin
        reg_hit = 1'b1;
        reg_sel = REG_MTIME_LO;
        case (offset)
            `CLINT_MTIMECMP_LO: reg_sel = REG_MTIMECMP_LO;
            `CLINT_MTIMECMP_HI: reg_sel = REG_MTIMECMP_HI;
            `CLINT_MTIME_LO:    reg_sel = REG_MTIME_LO;
            `CLINT_MTIME_HI:    reg_sel = REG_MTIME_HI;
            default:            reg_hit = 1'b0;
        endcase
    end

    // Read mux, unknown offsets read zero
    always_comb begin
        case (reg_sel)
            REG_MTIMECMP_LO: rd_word = mtimecmp[31:0];
            REG_MTIMECMP_HI: rd_word = mtimecmp[63:32];
            REG_MTIME_LO:    rd_word = mtime[31:0];
            default:         rd_word = mtime[63:32];
        endcase
        if (!reg_hit) begin
            rd_word = '0;
        end
    end

    assign access = bus_s.cyc & bus_s.stb & ~ack_q;

    always_ff @(posedge sys_clk or posedge sys_rst) begin
        if (sys_rst) begin
            mtime    <= '0;
            mtimecmp <= '1;
            ack_q    <= 1'b0;
        end else begin
            // Free-running, bus writes ignored
            mtime <= mtime + 64'd1;
            ack_q <= access;
            if (access && bus_s.we && reg_hit) begin
                if (reg_sel == REG_MTIMECMP_LO) begin
                    mtimecmp[31:0] <= merge_bytes(mtimecmp[31:0], bus_s.dat_w, bus_s.sel);
                end else if (reg_sel == REG_MTIMECMP_HI) begin
                    mtimecmp[63:32] <= merge_bytes(mtimecmp[63:32], bus_s.dat_w, bus_s.sel);
                end
            end
        end
    end

    // Read data captured with the ack
    always_ff @(posedge sys_clk) begin
        if (access) begin
            rd_q <= rd_word;
        end
    end

    assign bus_s.dat_r = rd_q;
    assign bus_s.ack   = ack_q;
    assign bus_s.err   = 1'b0;

    // Level interrupt
    assign timer_irq_o = (mtime >= mtimecmp);

endmodule

// File: design/soc_bus_top.sv
`timescale 1ns/1ps

module soc_bus_top (
    input  logic                 sys_clk,
    input  logic                 sys_rst,
    // Instruction master
    input  wb_bus_pkg::wb_addr_t inst_adr_i,
    input  wb_bus_pkg::wb_data_t inst_dat_i,
    input  logic                 inst_we_i,
    input  wb_bus_pkg::wb_sel_t  inst_sel_i,
    input  logic                 inst_stb_i,
    input  logic                 inst_cyc_i,
    output wb_bus_pkg::wb_data_t inst_dat_o,
    output logic                 inst_ack_o,
    output logic                 inst_err_o,
    // Data master
    input  wb_bus_pkg::wb_addr_t data_adr_i,
    input  wb_bus_pkg::wb_data_t data_dat_i,
    input  logic                 data_we_i,
    input  wb_bus_pkg::wb_sel_t  data_sel_i,
    input  logic                 data_stb_i,
    input  logic                 data_cyc_i,
    output wb_bus_pkg::wb_data_t data_dat_o,
    output logic                 data_ack_o,
    output logic                 data_err_o,
    // Timer interrupt
    output logic                 timer_irq_o
);

    wb_if bus_inst ();
    wb_if bus_data ();
    wb_if bus_m ();
    wb_if bus_ram0 ();
    wb_if bus_ram1 ();
    wb_if bus_clint ();

    // Plain ports onto the master buses
    assign bus_inst.adr   = inst_adr_i;
    assign bus_inst.dat_w = inst_dat_i;
    assign bus_inst.we    = inst_we_i;
    assign bus_inst.sel   = inst_sel_i;
    assign bus_inst.stb   = inst_stb_i;
    assign bus_inst.cyc   = inst_cyc_i;
    assign inst_dat_o     = bus_inst.dat_r;
    assign inst_ack_o     = bus_inst.ack;
    assign inst_err_o     = bus_inst.err;

    assign bus_data.adr   = data_adr_i;
    assign bus_data.dat_w = data_dat_i;
    assign bus_data.we    = data_we_i;
    assign bus_data.sel   = data_sel_i;
    assign bus_data.stb   = data_stb_i;
    assign bus_data.cyc   = data_cyc_i;
    assign data_dat_o     = bus_data.dat_r;
    assign data_ack_o     = bus_data.ack;
    assign data_err_o     = bus_data.err;

    wb_arbiter u_arbiter (
        .sys_clk (sys_clk),
        .sys_rst (sys_rst),
        .inst_m  (bus_inst),
        .data_m  (bus_data),
        .bus_m   (bus_m)
    );

    wb_addr_decoder u_decoder (
        .sys_clk   (sys_clk),
        .sys_rst   (sys_rst),
        .bus_s     (bus_m),
        .bus_ram0  (bus_ram0),
        .bus_ram1  (bus_ram1),
        .bus_clint (bus_clint)
    );

    // BaseRAM window stand-in
    wb_sram_slave u_ram0 (
        .sys_clk (sys_clk),
        .sys_rst (sys_rst),
        .bus_s   (bus_ram0)
    );

    // ExtRAM window stand-in
    wb_sram_slave u_ram1 (
        .sys_clk (sys_clk),
        .sys_rst (sys_rst),
        .bus_s   (bus_ram1)
    );

    clint_timer u_clint (
        .sys_clk     (sys_clk),
        .sys_rst     (sys_rst),
        .bus_s       (bus_clint),
        .timer_irq_o (timer_irq_o)
    );

endmodule

// File: verification/soc_bus_properties.sv
`timescale 1ns/1ps

module soc_bus_properties (
    input logic sys_clk,
    input logic sys_rst,
    input logic inst_cyc_i,
    input logic inst_ack_o,
    input logic inst_err_o,
    input logic data_cyc_i,
    input logic data_ack_o,
    input logic data_err_o
);

    // ack and err exclusive per master
    a_inst_excl: assert property (@(posedge sys_clk) disable iff (sys_rst)
        !(inst_ack_o && inst_err_o)) else $error("inst port has ack and err together");
    a_data_excl: assert property (@(posedge sys_clk) disable iff (sys_rst)
        !(data_ack_o && data_err_o)) else $error("data port has ack and err together");

    // Response only inside an open cycle
    a_inst_cyc: assert property (@(posedge sys_clk) disable iff (sys_rst)
        (inst_ack_o || inst_err_o) |-> inst_cyc_i)
        else $error("inst port response without cyc");
    a_data_cyc: assert property (@(posedge sys_clk) disable iff (sys_rst)
        (data_ack_o || data_err_o) |-> data_cyc_i)
        else $error("data port response without cyc");

    // One owner of the bus at a time
    a_one_ack: assert property (@(posedge sys_clk) disable iff (sys_rst)
        !(inst_ack_o && data_ack_o)) else $error("both ports acknowledged in one cycle");

endmodule

bind soc_bus_top soc_bus_properties u_bus_props (
    .sys_clk    (sys_clk),
    .sys_rst    (sys_rst),
    .inst_cyc_i (inst_cyc_i),
    .inst_ack_o (inst_ack_o),
    .inst_err_o (inst_err_o),
    .data_cyc_i (data_cyc_i),
    .data_ack_o (data_ack_o),
    .data_err_o (data_err_o)
);

// File: verification/tb_soc_bus.sv
`timescale 1ns/1ps
`include "bus_defs.svh"

module tb_soc_bus import wb_bus_pkg::*; #(
    parameter int unsigned SEED = 32'h18
);

    // Test size and watchdog budget
    localparam int N_OFFS          = 12;
    localparam int TXN_COUNT       = N_OFFS * 6 + 24;
    localparam int WATCHDOG_CYCLES = TXN_COUNT * 20 + 200;

    // Response kind as {err, ack}
    typedef enum logic [1:0] {
        RESP_NONE = 2'b00,
        RESP_ACK  = 2'b01,
        RESP_ERR  = 2'b10,
        RESP_BOTH = 2'b11
    } resp_e;

    typedef struct packed {
        resp_e    kind;
        logic     chk;
        wb_data_t data;
    } exp_t;

    logic     sys_clk;
    logic     sys_rst;
    wb_addr_t inst_adr_i;
    wb_data_t inst_dat_i;
    logic     inst_we_i;
    wb_sel_t  inst_sel_i;
    logic     inst_stb_i;
    logic     inst_cyc_i;
    wb_data_t inst_dat_o;
    logic     inst_ack_o;
    logic     inst_err_o;
    wb_addr_t data_adr_i;
    wb_data_t data_dat_i;
    logic     data_we_i;
    wb_sel_t  data_sel_i;
    logic     data_stb_i;
    logic     data_cyc_i;
    wb_data_t data_dat_o;
    logic     data_ack_o;
    logic     data_err_o;
    logic     timer_irq_o;

    // Reference memory windows
    wb_data_t    model0 [`RAM_WORDS];
    wb_data_t    model1 [`RAM_WORDS];
    // Pending expectations per master
    exp_t        inst_exp_q [$];
    exp_t        data_exp_q [$];
    logic [31:0] lcg_state = SEED;
    int unsigned offs [N_OFFS];

    soc_bus_top i_dut (.*);

    initial begin
        sys_clk = 1'b0;
        forever #2 sys_clk = ~sys_clk;
    end

    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    // Window response from the address map
    function automatic resp_e expected_kind(wb_addr_t adr);
        if ((adr & `RAM_MASK) == `RAM0_BASE || (adr & `RAM_MASK) == `RAM1_BASE) begin
            return RESP_ACK;
        end
        if ((adr & `CLINT_MASK) == `CLINT_BASE) begin
            return RESP_ACK;
        end
        return RESP_ERR;
    endfunction

    // Old word out and byte-select write applied to the model
    function automatic wb_data_t ref_mem(wb_addr_t adr, logic we, wb_data_t wdat, wb_sel_t sel);
        int       idx;
        wb_data_t old_w;
        wb_data_t new_w;
        idx = int'((adr >> 2) % `RAM_WORDS);
        if ((adr & `RAM_MASK) == `RAM0_BASE) begin
            old_w = model0[idx];
        end else if ((adr & `RAM_MASK) == `RAM1_BASE) begin
            old_w = model1[idx];
        end else begin
            return '0;
        end
        new_w = old_w;
        for (int b = 0; b < `WB_SEL_W; b++) begin
            if (sel[b]) begin
                new_w[8*b +: 8] = wdat[8*b +: 8];
            end
        end
        if (we && (adr & `RAM_MASK) == `RAM0_BASE) begin
            model0[idx] = new_w;
        end else if (we) begin
            model1[idx] = new_w;
        end
        return old_w;
    endfunction

    task automatic report_failure(string msg);
        $display("%s", msg);
        $display("Simulation failed");
        $fatal(1, "stopped at first error");
    endtask

    task automatic compare_data(string name, wb_data_t got, wb_data_t exp);
        if (got !== exp) begin
            report_failure($sformatf("MISMATCH %s got %08h expected %08h", name, got, exp));
        end
    endtask

    task automatic compare_kind(string name, resp_e got, resp_e exp);
        if (got !== exp) begin
            report_failure($sformatf("MISMATCH %s got %0h expected %0h", name, got, exp));
        end
    endtask

    task automatic compare_irq(logic got, logic exp);
        if (got !== exp) begin
            report_failure($sformatf("MISMATCH timer_irq_o got %0h expected %0h", got, exp));
        end
    endtask

    task automatic check_response(string who, exp_t e, logic ack, logic err, wb_data_t dat);
        compare_kind({who, "_resp"}, resp_e'({err, ack}), e.kind);
        if (e.chk) begin
            compare_data({who, "_dat_o"}, dat, e.data);
        end
    endtask

    // Compare each response against the oldest expectation
    always @(negedge sys_clk) begin
        if (!sys_rst && (data_ack_o || data_err_o)) begin
            if (data_exp_q.size() == 0) begin
                report_failure("data port answered with no request pending");
            end else begin
                check_response("data", data_exp_q.pop_front(), data_ack_o, data_err_o, data_dat_o);
            end
        end
        if (!sys_rst && (inst_ack_o || inst_err_o)) begin
            if (inst_exp_q.size() == 0) begin
                report_failure("instruction port answered with no request pending");
            end else begin
                check_response("inst", inst_exp_q.pop_front(), inst_ack_o, inst_err_o, inst_dat_o);
            end
        end
    end

    // Single-beat transfer with an edge count up to ack or err
    task automatic issue_request(input logic is_data, input wb_addr_t adr, input logic we,
                                 input wb_data_t wdat, input wb_sel_t sel, input exp_t e,
                                 output wb_data_t rdat, output int edges);
        logic done;
        edges = 0;
        done  = 1'b0;
        @(negedge sys_clk);
        if (is_data) begin
            data_exp_q.push_back(e);
            data_adr_i = adr;
            data_dat_i = wdat;
            data_we_i  = we;
            data_sel_i = sel;
            data_stb_i = 1'b1;
            data_cyc_i = 1'b1;
        end else begin
            inst_exp_q.push_back(e);
            inst_adr_i = adr;
            inst_dat_i = wdat;
            inst_we_i  = we;
            inst_sel_i = sel;
            inst_stb_i = 1'b1;
            inst_cyc_i = 1'b1;
        end
        while (!done) begin
            @(posedge sys_clk);
            edges++;
            @(negedge sys_clk);
            done = is_data ? (data_ack_o | data_err_o) : (inst_ack_o | inst_err_o);
        end
        rdat = is_data ? data_dat_o : inst_dat_o;
        // Request held through the ack cycle
        @(negedge sys_clk);
        // Only cyc and stb drop here
        if (is_data) begin
            data_stb_i = 1'b0;
            data_cyc_i = 1'b0;
        end else begin
            inst_stb_i = 1'b0;
            inst_cyc_i = 1'b0;
        end
    endtask

    task automatic memory_access(input logic is_data, input wb_addr_t adr, input logic we,
                                 input wb_data_t wdat, input wb_sel_t sel, output int edges);
        exp_t     e;
        wb_data_t rdat;
        e.data = ref_mem(adr, we, wdat, sel);
        e.kind = expected_kind(adr);
        e.chk  = !we && (e.kind == RESP_ACK);
        issue_request(is_data, adr, we, wdat, sel, e, rdat, edges);
    endtask

    task automatic timer_access(input logic we, input wb_addr_t offset, input wb_data_t wdat,
                                input logic chk, input wb_data_t exp_dat, output wb_data_t rdat);
        exp_t e;
        int   edges;
        e.kind = RESP_ACK;
        e.chk  = chk;
        e.data = exp_dat;
        issue_request(1'b1, `CLINT_BASE | offset, we, wdat, 4'hF, e, rdat, edges);
    endtask

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge sys_clk);
        report_failure($sformatf("Timeout: run did not finish in %0d cycles", WATCHDOG_CYCLES));
    end

    initial begin
        wb_addr_t a0;
        wb_addr_t a1;
        wb_data_t t0;
        wb_data_t t1;
        wb_data_t cmp_lo;
        int       edges;
        int       d_edges;
        int       i_edges;
        sys_rst    = 1'b1;
        inst_adr_i = '0;
        inst_dat_i = '0;
        inst_we_i  = 1'b0;
        inst_sel_i = '0;
        inst_stb_i = 1'b0;
        inst_cyc_i = 1'b0;
        data_adr_i = '0;
        data_dat_i = '0;
        data_we_i  = 1'b0;
        data_sel_i = '0;
        data_stb_i = 1'b0;
        data_cyc_i = 1'b0;
        repeat (3) @(posedge sys_clk);
        @(negedge sys_clk);
        sys_rst = 1'b0;

        // Quiet bus after reset
        @(negedge sys_clk);
        compare_kind("inst_resp", resp_e'({inst_err_o, inst_ack_o}), RESP_NONE);
        compare_kind("data_resp", resp_e'({data_err_o, data_ack_o}), RESP_NONE);
        compare_irq(timer_irq_o, 1'b0);

        // Word offsets with the first one at zero
        offs[0] = 0;
        for (int i = 1; i < N_OFFS; i++) begin
            offs[i] = (lcg_next() >> 8) % `RAM_WORDS;
        end

        // Full words first then byte-select writes and reads
        for (int i = 0; i < N_OFFS; i++) begin
            a0 = `RAM0_BASE + (offs[i] << 2);
            a1 = `RAM1_BASE + (offs[i] << 2);
            memory_access(1'b1, a0, 1'b1, lcg_next(), 4'hF, edges);
            memory_access(1'b1, a1, 1'b1, lcg_next(), 4'hF, edges);
            memory_access(1'b1, a0, 1'b1, lcg_next(), 4'(lcg_next() >> 16), edges);
            memory_access(1'b1, a1, 1'b1, lcg_next(), 4'(lcg_next() >> 16), edges);
            memory_access(1'b0, a0, 1'b0, '0, '0, edges);
            memory_access(1'b0, a1, 1'b0, '0, '0, edges);
        end

        // Idle bus latency
        memory_access(1'b1, `RAM0_BASE + (offs[1] << 2), 1'b0, '0, '0, edges);
        if (edges != 2) begin
            report_failure($sformatf("MISMATCH ack_latency got %0h expected %0h", edges, 2));
        end
        // Old UART window is unmapped
        memory_access(1'b1, 32'h1000_0000, 1'b1, 32'hDEAD_BEEF, 4'hF, edges);
        if (edges != 2) begin
            report_failure($sformatf("MISMATCH err_latency got %0h expected %0h", edges, 2));
        end
        memory_access(1'b0, `RAM0_BASE, 1'b0, '0, '0, edges);
        memory_access(1'b0, `RAM1_BASE, 1'b0, '0, '0, edges);

        // Both masters in the same cycle
        fork
            memory_access(1'b1, `RAM1_BASE + (offs[2] << 2), 1'b1, lcg_next(), 4'hF, d_edges);
            memory_access(1'b0, `RAM0_BASE + (offs[3] << 2), 1'b0, '0, '0, i_edges);
        join
        if (d_edges >= i_edges) begin
            report_failure($sformatf("data master finished after %0d edges, not before the %0d of inst",
                                     d_edges, i_edges));
        end
        memory_access(1'b1, `RAM1_BASE + (offs[2] << 2), 1'b0, '0, '0, edges);

        // mtime runs
        timer_access(1'b0, `CLINT_MTIME_LO, '0, 1'b0, '0, t0);
        timer_access(1'b0, `CLINT_MTIME_LO, '0, 1'b0, '0, t1);
        if (t1 <= t0) begin
            report_failure($sformatf("mtime did not advance, read %08h then %08h", t0, t1));
        end
        cmp_lo = lcg_next();
        timer_access(1'b1, `CLINT_MTIMECMP_LO, cmp_lo, 1'b0, '0, t0);
        timer_access(1'b0, `CLINT_MTIMECMP_LO, '0, 1'b1, cmp_lo, t0);
        @(negedge sys_clk);
        compare_irq(timer_irq_o, 1'b0);
        timer_access(1'b1, `CLINT_MTIMECMP_HI, 32'hFFFF_FFFF, 1'b0, '0, t0);
        timer_access(1'b0, `CLINT_MTIMECMP_HI, '0, 1'b1, 32'hFFFF_FFFF, t0);
        @(negedge sys_clk);
        compare_irq(timer_irq_o, 1'b0);
        // Zero compare value raises the interrupt
        timer_access(1'b1, `CLINT_MTIMECMP_LO, '0, 1'b0, '0, t0);
        timer_access(1'b1, `CLINT_MTIMECMP_HI, '0, 1'b0, '0, t0);
        @(negedge sys_clk);
        compare_irq(timer_irq_o, 1'b1);

        // Let the last response reach the checker
        repeat (2) @(negedge sys_clk);
        if (inst_exp_q.size() != 0 || data_exp_q.size() != 0) begin
            report_failure("requests still waiting for a response at the end of the run");
        end else begin
            $display("Simulation completed successfully");
            $finish;
        end
    end

endmodule

// File: compile.f
+incdir+design
design/wb_bus_pkg.sv
design/memory_map_pkg.sv
design/wb_if.sv
design/wb_arbiter.sv
design/wb_addr_decoder.sv
design/wb_sram_slave.sv
design/clint_timer.sv
design/soc_bus_top.sv
verification/soc_bus_properties.sv
verification/tb_soc_bus.sv

// File: Makefile
TOP       ?= tb_soc_bus
SEED      ?= 24
BUILD_DIR ?= build
FILELIST  ?= compile.f
LOG       ?= $(BUILD_DIR)/sim.log
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert

SOURCES := $(shell grep -v '^+' $(FILELIST)) $(wildcard design/*.svh)
BIN     := $(BUILD_DIR)/V$(TOP)

.PHONY: all run clean

all: $(BIN)

$(BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -GSEED=$(SEED) \
		--Mdir $(BUILD_DIR) -o V$(TOP)

run: $(BIN)
	$(BIN) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "Simulation failed" $(LOG); then echo "FAIL"; exit 1; fi
	@grep -q "Simulation completed successfully" $(LOG) || (echo "FAIL: no pass line"; exit 1)

clean:
	rm -rf $(BUILD_DIR)
